// ==== design/midi_msg_decoder.sv ====
/*
 * MIDI message decoder: running status, channel filter, two byte
 * channel messages turned into note and controller events
 */
module midi_msg_decoder (
    input  logic                   io_clk,
    input  logic                   io_reset,
    input  logic [7:0]             rx_byte,
    input  logic                   rx_valid,
    input  logic [3:0]             midi_ch,
    output synth_pkg::midi_event_t midi_event
);
    import synth_pkg::*;

    logic [3:0] status_type;   // upper nibble of last channel status
    logic       status_valid;
    logic       ch_match;      // latched when the status arrived
    logic       have_first;    // first data byte already held
    logic [6:0] first_byte;
    logic       two_byte;      // message carries two data bytes
    logic       is_data;
    logic       emit;
    midi_kind_e kind;
    midi_data_u data_word;

    assign is_data  = rx_valid && !rx_byte[7];
    // program change and channel pressure carry one data byte
    assign two_byte = (status_type != 4'hc) && (status_type != 4'hd);
    assign emit     = is_data && status_valid && ch_match && have_first &&
                      (kind != kind_none);

    //////////////////////////////////////////////////////////////
    // kind and data word for the byte now arriving
    //////////////////////////////////////////////////////////////
    always_comb begin
        data_word = '0;
        case (status_type)
            4'h8:    kind = kind_note_off;
            4'h9:    kind = (rx_byte[6:0] == 7'd0) ? kind_note_off : kind_note_on;
            4'hb:    kind = kind_ctrl;
            default: kind = kind_none;  // pitch bend, aftertouch etc
        endcase
        if (kind == kind_ctrl) begin
            data_word.ctrl.num   = first_byte;
            data_word.ctrl.value = rx_byte[6:0];
        end else begin
            data_word.note.key   = first_byte;
            data_word.note.vel   = rx_byte[6:0];
        end
    end

    always_ff @(posedge io_clk) begin
        if (io_reset) begin
            status_valid     <= 1'b0;
            ch_match         <= 1'b0;
            have_first       <= 1'b0;
            midi_event.valid <= 1'b0;
        end else begin
            midi_event.valid <= emit;
            if (rx_valid && rx_byte[7]) begin
                if (rx_byte[7:4] != 4'hf) begin    // system bytes dropped
                    status_type  <= rx_byte[7:4];
                    status_valid <= 1'b1;
                    ch_match     <= (rx_byte[3:0] == midi_ch);
                    have_first   <= 1'b0;
                end
            end else if (is_data && status_valid && ch_match) begin
                if (!have_first && two_byte) begin
                    have_first <= 1'b1;
                    first_byte <= rx_byte[6:0];
                end else begin
                    have_first <= 1'b0;            // running status restarts
                end
            end
        end
    end

    // payload, qualified by valid
    always_ff @(posedge io_clk) begin
        if (emit) begin
            midi_event.kind <= kind;
            midi_event.data <= data_word;
        end
    end

endmodule

// ==== design/midi_uart_rx.sv ====
/*
 * MIDI serial receiver, 8N1 with mid-bit sampling
 * pulses rx_valid once per byte with a good stop bit
 */
module midi_uart_rx #(
    parameter int clks_per_bit = 320
) (
    input  logic       io_clk,
    input  logic       io_reset,
    input  logic       midi_rxd,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    // first sample lands mid start bit; the sync and idle detect eat 2 cycles
    localparam int half_wait = clks_per_bit / 2 - 2;
    localparam int cw        = $clog2(clks_per_bit);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_e;

    rx_state_e  state;
    logic [1:0] sync;        // two flop synchronizer
    logic       rxd;         // synchronized line
    logic [cw-1:0] cnt;      // cycles within the bit
    logic [2:0] bit_idx;
    logic [7:0] shift;

    assign rxd = sync[1];

    always_ff @(posedge io_clk) begin
        if (io_reset) begin
            sync     <= 2'b11;  // line idles high
            state    <= st_idle;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync     <= {sync[0], midi_rxd};
            rx_valid <= 1'b0;
            cnt      <= cnt + 1'b1;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (!rxd) state <= st_start;   // falling edge of start bit
                end
                st_start: if (cnt == cw'(half_wait - 1)) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= rxd ? st_idle : st_data;  // glitch, back to idle
                end
                st_data: if (cnt == cw'(clks_per_bit - 1)) begin
                    cnt     <= '0;
                    shift   <= {rxd, shift[7:1]};  // lsb first
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= st_stop;
                end
                st_stop: if (cnt == cw'(clks_per_bit - 1)) begin
                    state <= st_idle;
                    if (rxd) begin                 // bad stop bit drops the byte
                        rx_byte  <= shift;
                        rx_valid <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== design/synth_pkg.sv ====
/*
 * synth package: decoded MIDI event types, the voice state record
 * and the CPU register map shared by the synthesizer blocks
 */
package synth_pkg;

    //////////////////////////////////////////////////////////////
    // decoded event kinds
    //////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        kind_none     = 2'd0,  // nothing useful, not emitted
        kind_note_on  = 2'd1,
        kind_note_off = 2'd2,  // includes note on with velocity 0
        kind_ctrl     = 2'd3   // control change
    } midi_kind_e;

    // the two data bytes of a channel message, msb of each byte is 0
    typedef union packed {
        struct packed {
            logic       key_pad;
            logic [6:0] key;
            logic       vel_pad;
            logic [6:0] vel;
        } note;
        struct packed {
            logic       num_pad;
            logic [6:0] num;    // controller number
            logic       val_pad;
            logic [6:0] value;
        } ctrl;
    } midi_data_u;

    typedef struct packed {
        logic       valid;  // one cycle pulse
        midi_kind_e kind;
        midi_data_u data;
    } midi_event_t;         // 19 bits

    // one voice slot of the allocator
    typedef struct packed {
        logic       active;
        logic [6:0] key;
        logic [6:0] vel;
    } voice_t;              // 15 bits

    localparam logic [6:0] ctrl_all_notes_off = 7'd123;

    //////////////////////////////////////////////////////////////
    // CPU byte offsets
    //////////////////////////////////////////////////////////////
    localparam logic [10:0] reg_midi_ch    = 11'h000;  // rw, 4 bits
    localparam logic [10:0] reg_voice_free = 11'h004;  // ro
    localparam logic [10:0] reg_keys_on    = 11'h008;  // ro
    localparam logic [10:0] reg_rsound     = 11'h300;  // ro, sign extended
    localparam logic [10:0] reg_lsound     = 11'h304;  // ro, sign extended

endpackage

// ==== design/synth_regs.sv ====
/*
 * CPU register block: writable MIDI channel, registered readback
 * of voice flags and the latest left and right samples
 */
module synth_regs #(
    parameter int voices = 8
) (
    input  logic               io_clk,
    input  logic               io_reset,
    input  logic               chipselect,
    input  logic               cpu_read,
    input  logic               cpu_write,
    input  logic [10:0]        address,
    input  logic [31:0]        writedata,
    output logic [31:0]        readdata,
    output logic [3:0]         midi_ch,
    input  logic [voices-1:0]  keys_on,
    input  logic [voices-1:0]  voice_free,
    input  logic signed [15:0] lsound_out,
    input  logic signed [15:0] rsound_out
);
    import synth_pkg::*;

    logic [31:0] rd_mux;   // readback value for the current address

    always_comb begin
        case (address)
            reg_midi_ch:    rd_mux = 32'(midi_ch);
            reg_voice_free: rd_mux = 32'(voice_free);
            reg_keys_on:    rd_mux = 32'(keys_on);
            reg_rsound:     rd_mux = {{16{rsound_out[15]}}, rsound_out};  // sign extend
            reg_lsound:     rd_mux = {{16{lsound_out[15]}}, lsound_out};
            default:        rd_mux = '0;     // unmapped
        endcase
    end

    always_ff @(posedge io_clk) begin
        if (io_reset) begin
            midi_ch  <= '0;
            readdata <= '0;
        end else begin
            if (chipselect && cpu_write && (address == reg_midi_ch))
                midi_ch <= writedata[3:0];
            if (chipselect && cpu_read)
                readdata <= rd_mux;              // held until the next read
        end
    end

endmodule

// ==== design/synthesizer.sv ====
/*
 * two channel MIDI synthesizer top level
 * receiver, decoder, voice allocator, tone mixer and CPU registers
 */
module synthesizer #(
    parameter int voices       = 8,
    parameter int clks_per_bit = 320,  // 31250 baud at 10 MHz
    parameter int sample_div   = 64
) (
    input  logic               io_clk,
    input  logic               io_reset,
    input  logic               midi_rxd,
    input  logic               chipselect,
    input  logic               cpu_read,
    input  logic               cpu_write,
    input  logic [10:0]        address,
    input  logic [31:0]        writedata,
    output logic [31:0]        readdata,
    output logic [voices-1:0]  keys_on,
    output logic [voices-1:0]  voice_free,
    output logic signed [15:0] lsound_out,
    output logic signed [15:0] rsound_out,
    output logic               sample_tick
);
    import synth_pkg::*;

    logic [7:0]             rx_byte;
    logic                   rx_valid;
    logic [3:0]             midi_ch;
    midi_event_t            midi_event;
    voice_t [voices-1:0]    voice_state;

    //////////////////////////////////////////////////////////////
    // serial in, decode, allocate, mix
    //////////////////////////////////////////////////////////////
    midi_uart_rx #(.clks_per_bit(clks_per_bit)) i_midi_uart_rx (
        .io_clk, .io_reset, .midi_rxd, .rx_byte, .rx_valid
    );

    midi_msg_decoder i_midi_msg_decoder (
        .io_clk, .io_reset, .rx_byte, .rx_valid, .midi_ch, .midi_event
    );

    voice_allocator #(.voices(voices)) i_voice_allocator (
        .io_clk, .io_reset, .midi_event, .voice_state, .keys_on, .voice_free
    );

    tone_mixer #(.voices(voices), .sample_div(sample_div)) i_tone_mixer (
        .io_clk, .io_reset, .voice_state, .lsound_out, .rsound_out, .sample_tick
    );

    // CPU side
    synth_regs #(.voices(voices)) i_synth_regs (
        .io_clk, .io_reset, .chipselect, .cpu_read, .cpu_write, .address,
        .writedata, .readdata, .midi_ch, .keys_on, .voice_free,
        .lsound_out, .rsound_out
    );

endmodule

// ==== design/tone_mixer.sv ====
/*
 * tone mixer: one square wave per voice, even voices summed to the
 * left sample and odd voices to the right, once per sample tick
 */
module tone_mixer #(
    parameter int voices     = 8,
    parameter int sample_div = 64
) (
    input  logic                           io_clk,
    input  logic                           io_reset,
    input  synth_pkg::voice_t [voices-1:0] voice_state,
    output logic signed [15:0]             lsound_out,
    output logic signed [15:0]             rsound_out,
    output logic                           sample_tick
);

    localparam int cw = (sample_div > 1) ? $clog2(sample_div) : 1;

    logic [cw-1:0]      div_cnt;
    logic               tick_now;         // last cycle of the sample period
    logic [15:0]        phase [voices];
    logic [7:0]         step  [voices];   // key + 1
    logic signed [15:0] amp   [voices];
    logic signed [15:0] lsum;
    logic signed [15:0] rsum;

    assign tick_now = (div_cnt == cw'(sample_div - 1));

    //////////////////////////////////////////////////////////////
    // square waves and adder trees
    //////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < voices; i++) begin
            step[i] = {1'b0, voice_state[i].key} + 8'd1;
            if (!voice_state[i].active)
                amp[i] = '0;
            else if (phase[i][15])                // second half of the period
                amp[i] = -$signed({5'd0, voice_state[i].vel, 4'd0});
            else
                amp[i] = $signed({5'd0, voice_state[i].vel, 4'd0});
        end
    end

    always_comb begin
        lsum = '0;
        rsum = '0;
        for (int i = 0; i < voices; i++) begin
            if (i % 2 == 0) lsum = lsum + amp[i];  // even voices left
            else            rsum = rsum + amp[i];
        end
    end

    // samples use the phase before this tick advances it
    always_ff @(posedge io_clk) begin
        if (io_reset) begin
            div_cnt     <= '0;
            sample_tick <= 1'b0;
            lsound_out  <= '0;
            rsound_out  <= '0;
            for (int i = 0; i < voices; i++) begin
                phase[i] <= '0;
            end
        end else begin
            sample_tick <= tick_now;               // high with the new samples
            div_cnt     <= tick_now ? '0 : div_cnt + 1'b1;
            if (tick_now) begin
                lsound_out <= lsum;
                rsound_out <= rsum;
            end
            for (int i = 0; i < voices; i++) begin
                if (!voice_state[i].active)
                    phase[i] <= '0;                // restart on next note
                else if (tick_now)
                    phase[i] <= phase[i] + {4'd0, step[i], 4'd0};
            end
        end
    end

endmodule

// ==== design/voice_allocator.sv ====
/*
 * voice allocator: lowest free voice on note on, key match on note off,
 * all voices cleared by the all notes off controller
 */
module voice_allocator #(
    parameter int voices = 8
) (
    input  logic                            io_clk,
    input  logic                            io_reset,
    input  synth_pkg::midi_event_t          midi_event,
    output synth_pkg::voice_t [voices-1:0]  voice_state,
    output logic [voices-1:0]               keys_on,
    output logic [voices-1:0]               voice_free
);
    import synth_pkg::*;

    localparam int vw = (voices > 1) ? $clog2(voices) : 1;

    logic [vw-1:0]     free_idx;   // lowest inactive voice
    logic              free_found;
    logic [voices-1:0] key_hit;    // active voices holding the event key
    logic              do_on;
    logic              do_off;
    logic              do_clear;

    //////////////////////////////////////////////////////////////
    // priority encoder and key comparator
    //////////////////////////////////////////////////////////////
    always_comb begin
        free_idx   = '0;
        free_found = 1'b0;
        for (int i = voices - 1; i >= 0; i--) begin  // lowest index wins
            if (!voice_state[i].active) begin
                free_idx   = vw'(i);
                free_found = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < voices; i++) begin
            key_hit[i] = voice_state[i].active &&
                         (voice_state[i].key == midi_event.data.note.key);
        end
    end

    assign do_on    = midi_event.valid && (midi_event.kind == kind_note_on) && free_found;
    assign do_off   = midi_event.valid && (midi_event.kind == kind_note_off);
    assign do_clear = midi_event.valid && (midi_event.kind == kind_ctrl) &&
                      (midi_event.data.ctrl.num == ctrl_all_notes_off);

    always_ff @(posedge io_clk) begin
        if (io_reset) begin
            for (int i = 0; i < voices; i++) begin
                voice_state[i].active <= 1'b0;
            end
        end else if (do_on) begin
            voice_state[free_idx].active <= 1'b1;    // no free voice, event lost
            voice_state[free_idx].key    <= midi_event.data.note.key;
            voice_state[free_idx].vel    <= midi_event.data.note.vel;
        end else if (do_off) begin
            for (int i = 0; i < voices; i++) begin
                if (key_hit[i]) voice_state[i].active <= 1'b0;
            end
        end else if (do_clear) begin
            for (int i = 0; i < voices; i++) begin
                voice_state[i].active <= 1'b0;
            end
        end
    end

    // status flags from the same active bits
    always_comb begin
        for (int i = 0; i < voices; i++) begin
            keys_on[i]    = voice_state[i].active;
            voice_free[i] = !voice_state[i].active;
        end
    end

endmodule

// ==== synthesizer.f ====
design/synth_pkg.sv
design/midi_uart_rx.sv
design/midi_msg_decoder.sv
design/voice_allocator.sv
design/tone_mixer.sv
design/synth_regs.sv
design/synthesizer.sv
testbench/synthesizer_sva.sv
testbench/tb_synthesizer.sv

// ==== testbench/synthesizer_sva.sv ====
/*
 * synthesizer checker: event pulse width, voice flag consistency,
 * sample tick width and silence while no voice plays
 */
module synthesizer_sva #(
    parameter int voices = 8
) (
    input  logic                   io_clk,
    input  logic                   io_reset,
    input  synth_pkg::midi_event_t midi_event,
    input  logic [voices-1:0]      keys_on,
    input  logic [voices-1:0]      voice_free,
    input  logic                   sample_tick,
    input  logic signed [15:0]     lsound_out,
    input  logic signed [15:0]     rsound_out
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;  // failed assertions so far

    ////////////////////////////////////////////////////////////
    // pulse widths
    ////////////////////////////////////////////////////////////
    event_one_cycle: assert property (@(posedge io_clk) disable iff (io_reset)
        midi_event.valid |=> !midi_event.valid)
        else begin
            fail_count++;
            $error("event valid held for 2 cycles");
        end

    tick_one_cycle: assert property (@(posedge io_clk) disable iff (io_reset)
        sample_tick |=> !sample_tick)
        else begin
            fail_count++;
            $error("sample_tick wider than 1 cycle");
        end

    // same registers drive both flags
    flags_exclusive: assert property (@(posedge io_clk) disable iff (io_reset)
        (keys_on & voice_free) == '0)
        else begin
            fail_count++;
            $error("voice both on and free");
        end

    // mixer used the voice state of the cycle before the tick
    silent_when_idle: assert property (@(posedge io_clk) disable iff (io_reset)
        sample_tick && ($past(keys_on) == '0) |-> (lsound_out == 0) && (rsound_out == 0))
        else begin
            fail_count++;
            $error("sound with no voice active");
        end

endmodule

bind synthesizer synthesizer_sva #(.voices(voices)) i_synthesizer_sva (
    .io_clk, .io_reset, .midi_event, .keys_on, .voice_free,
    .sample_tick, .lsound_out, .rsound_out
);

// ==== testbench/tb_synthesizer.sv ====
/*
 * synthesizer testbench: serial MIDI and CPU bus stimulus,
 * voice model, directed tests for allocation, filtering and sound
 */
module tb_synthesizer;
    timeunit 1ns;
    timeprecision 100ps;
    import synth_pkg::*;

    localparam int voices          = 8;
    localparam int clks_per_bit    = 16;
    localparam int sample_div      = 32;
    localparam int max_bytes       = 80;                 // more than the tests send
    localparam int serial_bits     = max_bytes * 10;
    localparam int watchdog_cycles = serial_bits * clks_per_bit + 2000;

    logic io_clk, io_reset, midi_rxd, chipselect, cpu_read, cpu_write, sample_tick;
    logic [10:0] address;
    logic [31:0] writedata, readdata, rng;
    logic [voices-1:0] keys_on, voice_free;
    logic signed [15:0] lsound_out, rsound_out;
    logic [3:0] chan;                                     // channel under test
    logic [7:0] model_status;                             // running status seen by the model
    logic m_active [voices];
    logic [6:0] m_key [voices];
    logic [6:0] m_vel [voices];
    int errors = 0;
    int checks = 0;

    synthesizer #(.voices(voices), .clks_per_bit(clks_per_bit), .sample_div(sample_div))
    i_synthesizer (
        .io_clk, .io_reset, .midi_rxd, .chipselect, .cpu_read, .cpu_write, .address,
        .writedata, .readdata, .keys_on, .voice_free, .lsound_out, .rsound_out, .sample_tick
    );

    initial begin
        io_clk = 1'b0;
        forever #50 io_clk = ~io_clk;  // 10 MHz
    end

    initial begin
        repeat (watchdog_cycles) @(posedge io_clk);
        $display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
        $display("Some tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);   // xorshift32
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [6:0] rand_vel();
        logic [31:0] r;
        r = next_rand();
        return (r[6:0] == 7'd0) ? 7'd1 : r[6:0];  // nonzero
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // voice rules of the allocator
    function automatic void model_note_on(input logic [6:0] key, input logic [6:0] vel);
        logic done;
        done = 1'b0;
        for (int i = 0; i < voices; i++) begin
            if (!done && !m_active[i]) begin   // lowest free voice
                m_active[i] = 1'b1;
                m_key[i]    = key;
                m_vel[i]    = vel;
                done        = 1'b1;
            end
        end
    endfunction

    function automatic void model_data(input logic [6:0] d1, input logic [6:0] d2);
        if (model_status[3:0] != chan) return;   // filtered channel
        for (int i = 0; i < voices; i++) begin
            if ((model_status[7:4] == 4'h8 || (model_status[7:4] == 4'h9 && d2 == 0)) &&
                m_key[i] == d1)
                m_active[i] = 1'b0;
            if (model_status[7:4] == 4'hb && d1 == ctrl_all_notes_off)
                m_active[i] = 1'b0;
        end
        if (model_status[7:4] == 4'h9 && d2 != 0) model_note_on(d1, d2);
    endfunction

    function automatic logic [voices-1:0] model_keys();
        logic [voices-1:0] v;
        for (int i = 0; i < voices; i++) v[i] = m_active[i];
        return v;
    endfunction

    task automatic check_voices(input string what);
        logic [voices-1:0] exp;
        exp = model_keys();
        check({what, " keys_on"}, keys_on, exp);
        check({what, " voice_free"}, voice_free, {24'd0, ~exp});
    endtask

    // 8N1 frame, lsb first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            midi_rxd <= frame[i];
            repeat (clks_per_bit) @(posedge io_clk);
        end
    endtask

    task automatic send_status(input logic [7:0] s);
        send_byte(s);
        model_status = s;
    endtask

    task automatic send_pair(input logic [6:0] d1, input logic [6:0] d2);
        send_byte({1'b0, d1});
        send_byte({1'b0, d2});
        model_data(d1, d2);
        repeat (2) @(posedge io_clk);  // stop bit to keys_on
    endtask

    task automatic send_msg(input logic [7:0] s, input logic [6:0] d1, input logic [6:0] d2);
        send_status(s);
        send_pair(d1, d2);
    endtask

    task automatic cpu_write_reg(input logic [10:0] addr, input logic [31:0] data);
        @(posedge io_clk);
        chipselect <= 1'b1;
        cpu_write  <= 1'b1;
        address    <= addr;
        writedata  <= data;
        @(posedge io_clk);
        chipselect <= 1'b0;
        cpu_write  <= 1'b0;
    endtask

    task automatic cpu_read_reg(input logic [10:0] addr, output logic [31:0] data);
        @(posedge io_clk);
        chipselect <= 1'b1;
        cpu_read   <= 1'b1;
        address    <= addr;
        @(posedge io_clk);              // sampled here
        chipselect <= 1'b0;
        cpu_read   <= 1'b0;
        @(posedge io_clk);
        data = readdata;
    endtask

    task automatic wait_tick();
        int n;
        n = 0;
        do begin
            @(posedge io_clk);
            n++;
        end while (!sample_tick && n < 2 * sample_div);
        if (!sample_tick) begin
            errors++;
            $display("sample_tick did not arrive within %0d cycles", 2 * sample_div);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_registers();
        logic [31:0] rd;
        cpu_read_reg(reg_voice_free, rd);
        check("voice_free after reset", rd, 32'hff);
        cpu_read_reg(reg_lsound, rd);
        check("lsound after reset", rd, 32'h0);
        cpu_read_reg(reg_rsound, rd);
        check("rsound after reset", rd, 32'h0);
        cpu_write_reg(reg_midi_ch, {28'h1234567, chan});  // upper bits ignored
        cpu_read_reg(reg_midi_ch, rd);
        check("midi channel readback", rd, {28'd0, chan});
        cpu_read_reg(11'h010, rd);
        check("unmapped read", rd, 32'h0);
    endtask

    task automatic test_allocation();
        logic [31:0] rd;
        repeat (voices + 1) begin               // last one finds no voice
            send_msg({4'h9, chan}, next_rand() % 128, rand_vel());
            check_voices("allocation");
        end
        cpu_read_reg(reg_voice_free, rd);
        check("voice_free when full", rd, 32'h0);
    endtask

    task automatic test_release();
        send_msg({4'h8, chan}, m_key[2], 7'd64);
        check_voices("note off");
        send_msg({4'h9, chan}, m_key[5], 7'd0);  // velocity 0 releases
        check_voices("note on vel 0");
        send_msg({4'h9, chan}, next_rand() % 128, rand_vel());
        check_voices("reuse freed voice");
    endtask

    task automatic test_channel();
        send_msg({4'hb, chan}, ctrl_all_notes_off, 7'd0);
        check_voices("clear before filter");
        send_msg({4'h9, chan + 4'd1}, 7'd60, 7'd100);
        check_voices("other channel");
        send_status({4'h9, chan});
        send_pair(next_rand() % 128, rand_vel());
        check_voices("running status first pair");
        send_pair(next_rand() % 128, rand_vel());
        check_voices("running status second pair");
        send_status({4'h9, chan + 4'd1});
        send_pair(7'd61, 7'd90);
        check_voices("running status other channel");
    endtask

    task automatic test_controllers();
        send_msg({4'hb, chan}, 7'd7, 7'd100);   // volume, no effect here
        check_voices("other controller");
        send_msg({4'hb, chan}, ctrl_all_notes_off, 7'd0);
        check_voices("all notes off");
    endtask

    task automatic test_sound();
        logic [6:0] key, vel;
        logic [15:0] phase;
        logic signed [15:0] amp;                // expected left sample
        logic [31:0] rd;
        key   = 7'd64 + 7'(next_rand() % 64);  // fast enough to change sign
        vel   = rand_vel();
        phase = '0;
        amp   = '0;
        wait_tick();
        repeat (16) @(posedge io_clk);          // note lands mid period
        send_msg({4'h9, chan}, key, vel);
        check_voices("sound note");
        repeat (40) begin
            wait_tick();
            amp = 16'(int'(vel) * 16);
            if (phase[15]) amp = -amp;
            check("lsound sample", lsound_out, amp);
            check("rsound sample", rsound_out, 32'h0);
            phase = phase + 16'((int'(key) + 1) * 16);
        end
        cpu_read_reg(reg_lsound, rd);          // read within the same period
        check("lsound readback", rd, amp);     // amp widens with its sign
        cpu_read_reg(reg_rsound, rd);
        check("rsound readback", rd, 32'h0);
    endtask

    initial begin
        io_reset   = 1'b1;
        midi_rxd   = 1'b1;                      // line idle
        chipselect = 1'b0;
        cpu_read   = 1'b0;
        cpu_write  = 1'b0;
        address    = '0;
        writedata  = '0;
        rng        = 32'd20;
        model_status = '0;
        for (int i = 0; i < voices; i++) m_active[i] = 1'b0;
        chan = 4'(next_rand());
        repeat (10) @(posedge io_clk);
        io_reset <= 1'b0;
        @(posedge io_clk);
        test_registers();
        test_allocation();
        test_release();
        test_channel();
        test_controllers();
        test_sound();
        errors += i_synthesizer.i_synthesizer_sva.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 i_synthesizer.i_synthesizer_sva.fail_count);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
